// File: riscvCore.f
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/alu.sv
logic/decoder.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/dataPath.sv
logic/riscvCore.sv
verification/core_assertions.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps -f riscvCore.f --top-module coreTb -o coreSim
output=$(./obj_dir/coreSim 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "Regression passed"; then
	exit 0
fi
exit 1

// File: verification/coreTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module coreTb;

	localparam logic [31:0] poisonAddr = 32'd240;
	localparam logic [31:0] markerAddr = 32'd252;
	localparam logic [31:0] markerValue = 32'h0000_05a5;
	// program is about 50 instructions, under 150 cycles with stalls and redirects
	localparam int cycleLimit = 400;

	logic clk;
	logic reset;
	logic [`XLEN-1:0] instr = '0;
	logic [`XLEN-1:0] readData = '0;
	logic [`XLEN-1:0] pc, memAddr, memWriteData;
	logic memWrite, fetchStall;

	logic [31:0] rom [64];
	logic [31:0] ram [64];
	logic [31:0] seedWords [8];
	logic [31:0] expData [64];
	logic expSet [64];
	logic [31:0] fetchAddr, readAddr, loadUseWord, untakenAddr;
	logic sawLoadUseStall, sawUntakenStore;
	int progLen;
	int slot;
	int cycleCount = 0;

	riscvCore uut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, rs1, rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encodeI(input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	// base register is always x0
	function automatic logic [31:0] encodeStore(input logic [4:0] rs2, input logic [11:0] offset);
		return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encodeBranch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
			input logic [12:0] offset);
		return {offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encodeJal(input logic [4:0] rd, input logic [20:0] offset);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] word);
		rom[progLen] = word;
		progLen++;
	endtask

	// store a register to the next result slot and record what it must hold
	task automatic storeResult(input logic [4:0] rs, input logic [31:0] value);
		emit(encodeStore(rs, 12'(slot * 4)));
		expData[slot] = value;
		expSet[slot] = 1'b1;
		slot++;
	endtask

	task automatic stopWithFailure();
		$display("Regression failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
		if (addr == untakenAddr)
			sawUntakenStore = 1'b1;
		if (addr[31:8] != '0 || !expSet[addr[7:2]]) begin
			$display("a store went to the unexpected address %h", addr);
			stopWithFailure();
		end else begin
			assert (data == expData[addr[7:2]])
			else begin
				$display("FAILED at %0t: store to %h wrote %h, expected %h",
					$time, addr, data, expData[addr[7:2]]);
				stopWithFailure();
			end
		end
	endtask

	task automatic finishRun(input logic [31:0] marker);
		assert (sawLoadUseStall)
		else $display("fetchStall never went high for the load-use hazard");
		assert (sawUntakenStore)
		else $display("the store after the untaken bne never happened");
		assert (marker == markerValue)
		else $display("FAILED at %0t: end marker is %h, expected %h", $time, marker, markerValue);
		if (sawLoadUseStall && sawUntakenStore && marker == markerValue) begin
			$display("Regression passed");
			$finish;
		end else begin
			stopWithFailure();
		end
	endtask

	initial begin
		logic [31:0] state;
		logic [31:0] chained;
		logic [31:0] jalAddr;
		state = 32'h8c6df36a;
		for (int i = 0; i < 8; i++) begin
			state = xorshift(state);
			seedWords[i] = state;
		end
		for (int i = 0; i < 64; i++) begin
			rom[i] = '0;
			expData[i] = '0;
			expSet[i] = 1'b0;
		end
		progLen = 0;
		slot = 16;
		// x1..x4 from data words 0..3
		for (int i = 0; i < 4; i++)
			emit(encodeI(7'b0000011, 3'b010, 5'(i + 1), 5'd0, 12'(i * 4)));
		emit(encodeR(7'h00, 3'b000, 5'd5, 5'd1, 5'd2));
		storeResult(5'd5, seedWords[0] + seedWords[1]);
		emit(encodeR(7'h20, 3'b000, 5'd5, 5'd1, 5'd2));
		storeResult(5'd5, seedWords[0] - seedWords[1]);
		emit(encodeR(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
		storeResult(5'd5, seedWords[0] & seedWords[1]);
		emit(encodeR(7'h00, 3'b110, 5'd5, 5'd1, 5'd2));
		storeResult(5'd5, seedWords[0] | seedWords[1]);
		emit(encodeR(7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
		storeResult(5'd5, seedWords[0] ^ seedWords[1]);
		emit(encodeR(7'h00, 3'b010, 5'd5, 5'd1, 5'd2));
		storeResult(5'd5, {31'b0, $signed(seedWords[0]) < $signed(seedWords[1])});
		// shift amount is the low five bits of x3
		emit(encodeR(7'h00, 3'b001, 5'd5, 5'd1, 5'd3));
		storeResult(5'd5, seedWords[0] << seedWords[2][4:0]);
		emit(encodeR(7'h00, 3'b101, 5'd5, 5'd1, 5'd3));
		storeResult(5'd5, seedWords[0] >> seedWords[2][4:0]);
		emit(encodeI(7'b0010011, 3'b000, 5'd5, 5'd1, 12'hffb));
		storeResult(5'd5, seedWords[0] - 32'd5);
		emit(encodeI(7'b0010011, 3'b100, 5'd5, 5'd2, 12'h123));
		storeResult(5'd5, seedWords[1] ^ 32'h123);
		emit({20'habcde, 5'd5, 7'b0110111});
		storeResult(5'd5, 32'habcde000);
		// dependent chain at distance one and two
		chained = seedWords[0] + seedWords[1];
		emit(encodeR(7'h00, 3'b000, 5'd6, 5'd1, 5'd2));
		emit(encodeR(7'h00, 3'b000, 5'd7, 5'd6, 5'd3));
		emit(encodeR(7'h00, 3'b000, 5'd8, 5'd6, 5'd7));
		storeResult(5'd8, chained + (chained + seedWords[2]));
		// load-use
		emit(encodeI(7'b0000011, 3'b010, 5'd9, 5'd0, 12'd16));
		loadUseWord = encodeR(7'h00, 3'b000, 5'd10, 5'd9, 5'd4);
		emit(loadUseWord);
		storeResult(5'd10, seedWords[4] + seedWords[3]);
		// taken beq over a poison store, then an untaken bne on a fresh result
		emit(encodeBranch(3'b000, 5'd1, 5'd1, 13'd8));
		emit(encodeStore(5'd1, 12'(poisonAddr)));
		emit(encodeR(7'h00, 3'b000, 5'd11, 5'd2, 5'd0));
		emit(encodeBranch(3'b001, 5'd11, 5'd2, 13'd8));
		untakenAddr = 32'(slot * 4);
		storeResult(5'd11, seedWords[1]);
		jalAddr = 32'(progLen * 4);
		emit(encodeJal(5'd12, 21'd8));
		emit(encodeStore(5'd1, 12'(poisonAddr)));
		storeResult(5'd12, jalAddr + 32'd4);
		emit(encodeI(7'b0010011, 3'b000, 5'd0, 5'd1, 12'd5));
		storeResult(5'd0, 32'd0);
		emit(encodeI(7'b0010011, 3'b000, 5'd13, 5'd0, 12'(markerValue)));
		emit(encodeStore(5'd13, 12'(markerAddr)));
		// park on a self loop
		emit(encodeJal(5'd0, 21'd0));
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
	end

	// both memories latch their address on the rising edge
	always @(posedge clk) begin
		if (!fetchStall)
			fetchAddr <= pc;
		readAddr <= memAddr;
		if (reset) begin
			for (int i = 0; i < 64; i++)
				ram[i] <= '0;
			for (int i = 0; i < 8; i++)
				ram[i] <= seedWords[i];
			sawLoadUseStall = 1'b0;
			sawUntakenStore = 1'b0;
		end else begin
			if (fetchStall && instr == loadUseWord)
				sawLoadUseStall = 1'b1;
			if (memWrite) begin
				ram[memAddr[7:2]] <= memWriteData;
				if (memAddr == markerAddr)
					finishRun(memWriteData);
				else
					checkStore(memAddr, memWriteData);
			end
		end
	end

	always @(negedge clk) begin
		instr <= rom[fetchAddr[7:2]];
		readData <= ram[readAddr[7:2]];
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("timeout, the end marker was not stored within %0d cycles", cycleLimit);
			stopWithFailure();
		end
	end

	// every skipped store targets the same address
	assert property (@(posedge clk) disable iff (reset) !(memWrite && memAddr == poisonAddr))
	else begin
		$display("a skipped store wrote address %h", poisonAddr);
		stopWithFailure();
	end

endmodule

`default_nettype wire

// File: verification/core_assertions.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module coreAssertions (
	input logic             clk, reset,
	input logic [`XLEN-1:0] pc, memAddr,
	input logic             memWrite, fetchStall
);

	// execute stage comes out of reset empty
	afterReset: assert property (@(posedge clk) reset |=> !memWrite)
		else $error("memWrite high in the cycle after reset");

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	knownOutputs: assert property (@(posedge clk) disable iff (reset)
		!$isunknown({memWrite, memAddr, fetchStall}))
		else $error("memWrite, memAddr or fetchStall is unknown");

endmodule

bind riscvCore coreAssertions checks (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.memAddr(memAddr),
	.memWrite(memWrite),
	.fetchStall(fetchStall)
);

`default_nettype wire

// File: logic/riscvCore.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module riscvCore (
	input  logic             clk, reset,
	input  logic [`XLEN-1:0] instr, readData,
	output logic [`XLEN-1:0] pc, memAddr, memWriteData,
	output logic             memWrite, fetchStall
);
	import pipePkg::*;

	localparam int regAddrW = $clog2(`REG_COUNT);

	logic [regAddrW-1:0] rs1Addr, rs2Addr, rdAddr, rs1Ex, rs2Ex, rdEx, rdMem;
	logic [`XLEN-1:0] rs1Data, rs2Data, rdData;
	logic regWrite, regWriteEx, regWriteMem, branchDec, jumpDec;
	logic stallFetch, stallDecode, flushExecute;
	wbSelT wbSelEx;
	fwdSelT fwdRs1Dec, fwdRs2Dec, fwdRs1Ex, fwdRs2Ex;

	dataPath pipeline (.*);

	regFile registers (.*);

	hazardUnit hazards (
		.rs1Dec(rs1Addr), .rs2Dec(rs2Addr), .rs1Ex, .rs2Ex, .rdEx, .rdMem, .rdWb(rdAddr),
		.regWriteEx, .regWriteMem, .regWriteWb(regWrite), .wbSelEx, .branchDec, .jumpDec,
		.stallFetch, .stallDecode, .flushExecute,
		.fwdRs1Dec, .fwdRs2Dec, .fwdRs1Ex, .fwdRs2Ex
	);

endmodule

`default_nettype wire

// File: logic/dataPath.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module dataPath (
	input  logic                          clk, reset,
	input  logic [`XLEN-1:0]              instr, readData, rs1Data, rs2Data,
	input  logic                          stallFetch, stallDecode, flushExecute,
	input  pipePkg::fwdSelT               fwdRs1Dec, fwdRs2Dec, fwdRs1Ex, fwdRs2Ex,
	output logic [`XLEN-1:0]              pc, memAddr, memWriteData,
	output logic                          memWrite, fetchStall,
	output logic [$clog2(`REG_COUNT)-1:0] rs1Addr, rs2Addr,
	output logic                          regWrite,
	output logic [$clog2(`REG_COUNT)-1:0] rdAddr,
	output logic [`XLEN-1:0]              rdData,
	output logic [$clog2(`REG_COUNT)-1:0] rs1Ex, rs2Ex, rdEx, rdMem,
	output logic                          regWriteEx, regWriteMem,
	output pipePkg::wbSelT                wbSelEx,
	output logic                          branchDec, jumpDec
);
	import pipePkg::*;

	localparam int regAddrW = $clog2(`REG_COUNT);

	logic [`XLEN-1:0] pcDec, instrDec, immDec, opADec, opBDec;
	logic validDec;
	logic [regAddrW-1:0] rdDec;
	aluOpT aluOpDec, aluOpEx;
	logic useImmDec, regWriteDec, memWriteDec, branchOnEqualDec;
	wbSelT wbSelDec, wbSelMem;
	logic branchTaken, redirect;
	logic [`XLEN-1:0] pcPlus4Ex, opAEx, opBEx, immEx, srcAEx, srcBEx, aluResultEx;
	logic useImmEx, memWriteEx;
	logic [`XLEN-1:0] aluResultMem, pcPlus4Mem, resultMem;

	function automatic logic [`XLEN-1:0] pickOperand(input fwdSelT sel,
			input logic [`XLEN-1:0] regVal, memVal, wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	// fetch
	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else if (redirect)
			pc <= pcDec + immDec;
		else if (!stallFetch)
			pc <= pc + `XLEN'(4);
	end

	// word after a redirect is dropped in decode
	always_ff @(posedge clk) begin
		if (reset)
			validDec <= 1'b0;
		else if (!stallDecode)
			validDec <= !redirect;
	end

	always_ff @(posedge clk) begin
		if (!stallDecode)
			pcDec <= pc;
	end

	assign instrDec = validDec ? instr : '0;

	decoder decodeUnit (
		.instr(instrDec), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdDec),
		.imm(immDec), .aluOp(aluOpDec), .useImm(useImmDec), .regWrite(regWriteDec),
		.memWrite(memWriteDec), .wbSel(wbSelDec), .isBranch(branchDec), .isJal(jumpDec),
		.branchOnEqual(branchOnEqualDec)
	);

	// branch resolution in decode
	assign opADec = pickOperand(fwdRs1Dec, rs1Data, resultMem, rdData);
	assign opBDec = pickOperand(fwdRs2Dec, rs2Data, resultMem, rdData);
	assign branchTaken = branchDec && ((opADec == opBDec) == branchOnEqualDec);
	assign redirect = (branchTaken || jumpDec) && !stallDecode;
	assign fetchStall = stallFetch || redirect;

	always_ff @(posedge clk) begin
		if (reset || flushExecute) begin
			regWriteEx <= 1'b0;
			memWriteEx <= 1'b0;
			wbSelEx <= wbAlu;
			aluOpEx <= aluAdd;
			useImmEx <= 1'b0;
			rdEx <= '0;
			rs1Ex <= '0;
			rs2Ex <= '0;
		end else begin
			regWriteEx <= regWriteDec;
			memWriteEx <= memWriteDec;
			wbSelEx <= wbSelDec;
			aluOpEx <= aluOpDec;
			useImmEx <= useImmDec;
			rdEx <= rdDec;
			rs1Ex <= rs1Addr;
			rs2Ex <= rs2Addr;
		end
	end

	always_ff @(posedge clk) begin
		pcPlus4Ex <= pcDec + `XLEN'(4);
		opAEx <= opADec;
		opBEx <= opBDec;
		immEx <= immDec;
	end

	// execute
	assign srcAEx = pickOperand(fwdRs1Ex, opAEx, resultMem, rdData);
	assign srcBEx = pickOperand(fwdRs2Ex, opBEx, resultMem, rdData);

	alu aluUnit (
		.a(srcAEx), .b(useImmEx ? immEx : srcBEx), .aluOp(aluOpEx), .result(aluResultEx)
	);

	assign memAddr = aluResultEx;
	assign memWriteData = srcBEx;
	assign memWrite = memWriteEx;

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteMem <= 1'b0;
			rdMem <= '0;
			wbSelMem <= wbAlu;
		end else begin
			regWriteMem <= regWriteEx;
			rdMem <= rdEx;
			wbSelMem <= wbSelEx;
		end
	end

	always_ff @(posedge clk) begin
		aluResultMem <= aluResultEx;
		pcPlus4Mem <= pcPlus4Ex;
	end

	// load data arrives in this stage
	always_comb begin
		case (wbSelMem)
			wbMem:     resultMem = readData;
			wbPcPlus4: resultMem = pcPlus4Mem;
			default:   resultMem = aluResultMem;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regWrite <= 1'b0;
			rdAddr <= '0;
		end else begin
			regWrite <= regWriteMem;
			rdAddr <= rdMem;
		end
	end

	always_ff @(posedge clk) begin
		rdData <= resultMem;
	end

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module hazardUnit (
	input  logic [$clog2(`REG_COUNT)-1:0] rs1Dec, rs2Dec, rs1Ex, rs2Ex,
	input  logic [$clog2(`REG_COUNT)-1:0] rdEx, rdMem, rdWb,
	input  logic                          regWriteEx, regWriteMem, regWriteWb,
	input  pipePkg::wbSelT                wbSelEx,
	input  logic                          branchDec, jumpDec,
	output logic                          stallFetch, stallDecode, flushExecute,
	output pipePkg::fwdSelT               fwdRs1Dec, fwdRs2Dec, fwdRs1Ex, fwdRs2Ex
);
	import pipePkg::*;

	localparam int regAddrW = $clog2(`REG_COUNT);

	logic exWritesRs1, exWritesRs2;
	logic loadUse, branchWait;

	// memory stage has priority over writeback
	function automatic fwdSelT pickSource(input logic [regAddrW-1:0] src,
			input logic [regAddrW-1:0] rdM, rdW, input logic wrM, wrW);
		if (src != '0 && wrM && rdM == src)
			return fwdMem;
		if (src != '0 && wrW && rdW == src)
			return fwdWb;
		return fwdReg;
	endfunction

	always_comb begin
		fwdRs1Dec = pickSource(rs1Dec, rdMem, rdWb, regWriteMem, regWriteWb);
		fwdRs2Dec = pickSource(rs2Dec, rdMem, rdWb, regWriteMem, regWriteWb);
		fwdRs1Ex = pickSource(rs1Ex, rdMem, rdWb, regWriteMem, regWriteWb);
		fwdRs2Ex = pickSource(rs2Ex, rdMem, rdWb, regWriteMem, regWriteWb);
	end

	assign exWritesRs1 = regWriteEx && rdEx != '0 && rdEx == rs1Dec;
	assign exWritesRs2 = regWriteEx && rdEx != '0 && rdEx == rs2Dec;

	// jal reads no register
	assign loadUse = wbSelEx == wbMem && (exWritesRs1 || exWritesRs2) && !jumpDec;

	// branch compare in decode cannot see a result still in execute
	assign branchWait = branchDec && (exWritesRs1 || exWritesRs2);

	assign stallFetch = loadUse || branchWait;
	assign stallDecode = stallFetch;
	assign flushExecute = stallFetch;

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module regFile (
	input  logic                          clk, reset,
	input  logic [$clog2(`REG_COUNT)-1:0] rs1Addr, rs2Addr,
	input  logic                          regWrite,
	input  logic [$clog2(`REG_COUNT)-1:0] rdAddr,
	input  logic [`XLEN-1:0]              rdData,
	output logic [`XLEN-1:0]              rs1Data, rs2Data
);
	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (regWrite && rdAddr != '0) begin
			regs[rdAddr] <= rdData;
		end
	end

	// same-cycle write is visible to the reads
	always_comb begin
		if (rs1Addr == '0)
			rs1Data = '0;
		else if (regWrite && rdAddr == rs1Addr)
			rs1Data = rdData;
		else
			rs1Data = regs[rs1Addr];
		if (rs2Addr == '0)
			rs2Data = '0;
		else if (regWrite && rdAddr == rs2Addr)
			rs2Data = rdData;
		else
			rs2Data = regs[rs2Addr];
	end

endmodule

`default_nettype wire

// File: logic/decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module decoder (
	input  logic [`XLEN-1:0]              instr,
	output logic [$clog2(`REG_COUNT)-1:0] rs1Addr, rs2Addr, rdAddr,
	output logic [`XLEN-1:0]              imm,
	output pipePkg::aluOpT                aluOp,
	output logic                          useImm, regWrite, memWrite,
	output pipePkg::wbSelT                wbSel,
	output logic                          isBranch, isJal, branchOnEqual
);
	import isaPkg::*;
	import pipePkg::*;

	opcodeT opcode;
	funct3T funct3;
	logic readsRs1, readsRs2;
	logic [`XLEN-1:0] immI, immS, immB, immJ, immU;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = funct3T'(instr[14:12]);

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign immU = {instr[31:12], 12'b0};

	// unread operands show as x0 so they never cause a hazard
	assign rs1Addr = readsRs1 ? instr[19:15] : '0;
	assign rs2Addr = readsRs2 ? instr[24:20] : '0;
	assign rdAddr = instr[11:7];

	always_comb begin
		imm = '0;
		aluOp = aluAdd;
		useImm = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		wbSel = wbAlu;
		isBranch = 1'b0;
		isJal = 1'b0;
		branchOnEqual = 1'b0;
		readsRs1 = 1'b0;
		readsRs2 = 1'b0;
		case (opcode)
			opImm, opReg: begin
				readsRs1 = 1'b1;
				readsRs2 = (opcode == opReg);
				useImm = (opcode == opImm);
				imm = immI;
				regWrite = 1'b1;
				case (funct3)
					f3AddSub: aluOp = (opcode == opReg && instr[30]) ? aluSub : aluAdd;
					f3Sll:    aluOp = aluSll;
					f3Slt:    aluOp = aluSlt;
					f3Xor:    aluOp = aluXor;
					f3Srl:    aluOp = aluSrl;
					f3Or:     aluOp = aluOr;
					f3And:    aluOp = aluAnd;
					default:  regWrite = 1'b0;
				endcase
			end
			opLoad: begin
				readsRs1 = 1'b1;
				useImm = 1'b1;
				imm = immI;
				regWrite = 1'b1;
				wbSel = wbMem;
			end
			opStore: begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
				useImm = 1'b1;
				imm = immS;
				memWrite = 1'b1;
			end
			opBranch: begin
				imm = immB;
				if (funct3 == f3Beq || funct3 == f3Bne) begin
					isBranch = 1'b1;
					branchOnEqual = (funct3 == f3Beq);
					readsRs1 = 1'b1;
					readsRs2 = 1'b1;
				end
			end
			opJal: begin
				imm = immJ;
				isJal = 1'b1;
				regWrite = 1'b1;
				wbSel = wbPcPlus4;
			end
			opLui: begin
				imm = immU;
				useImm = 1'b1;
				aluOp = aluPassB;
				regWrite = 1'b1;
			end
			default: begin
				// anything else is a no-op
				regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscv_config.svh"

module alu (
	input  logic [`XLEN-1:0] a, b,
	input  pipePkg::aluOpT   aluOp,
	output logic [`XLEN-1:0] result
);
	import pipePkg::*;

	always_comb begin
		case (aluOp)
			aluAdd:   result = a + b;
			aluSub:   result = a - b;
			aluAnd:   result = a & b;
			aluOr:    result = a | b;
			aluXor:   result = a ^ b;
			// signed compare
			aluSlt:   result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			aluSll:   result = a << b[4:0];
			aluSrl:   result = a >> b[4:0];
			aluPassB: result = b;
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/pipePkg.sv
`default_nettype none

package pipePkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassB
	} aluOpT;

	// writeback source
	typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelT;

	// operand source, register file or a later stage
	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

endpackage

`default_nettype wire

// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opLui    = 7'b0110111
	} opcodeT;

	typedef enum logic [2:0] {
		f3AddSub = 3'b000,
		f3Sll    = 3'b001,
		f3Slt    = 3'b010,
		f3Xor    = 3'b100,
		f3Srl    = 3'b101,
		f3Or     = 3'b110,
		f3And    = 3'b111
	} funct3T;

	// branch codes share encodings with the ALU ones
	localparam funct3T f3Beq = f3AddSub;
	localparam funct3T f3Bne = f3Sll;

endpackage

`default_nettype wire

// File: logic/riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// data and address width
`define XLEN 32

// address of the first fetch
`define RESET_PC 32'h0000_0000

// architectural registers, x0 included
`define REG_COUNT 32

`endif
